// File: mips_pkg.sv
package mips_pkg;

	//////////////////////////////////////////////////
	// machine types
	//////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	typedef enum logic [5:0] {
		op_special = 6'h00, // an r-type names its operation in the function field.
		op_j       = 6'h02,
		op_jal     = 6'h03,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	//////////////////////////////////////////////////
	// control bundle fields
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_sll,
		alu_lui
	} alu_op_e;

	typedef enum logic [2:0] {
		pc_seq,
		pc_beq,
		pc_bne,
		pc_jump,
		pc_jr
	} pc_action_e;

	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_src_e;
	typedef enum logic {imm_signed, imm_zero} imm_mode_e;
	typedef enum logic [1:0] {b_reg, b_imm, b_shamt} b_src_e;
	typedef enum logic [1:0] {wr_rd, wr_rt, wr_r31} wr_sel_e;

endpackage

// File: mips_ctrl_if.sv
`timescale 1ns/1ps

interface mips_ctrl_if;
	import mips_pkg::*;

	alu_op_e    alu_op;
	b_src_e     b_src;
	imm_mode_e  imm_mode;
	wr_sel_e    wr_sel;
	logic       reg_we;
	wb_src_e    wb_src;
	logic       mem_we;
	pc_action_e pc_action;

	// all fields are plain levels held for the whole instruction cycle.
	modport decoder (
		output alu_op,
		output b_src,
		output imm_mode,
		output wr_sel,
		output reg_we,
		output wb_src,
		output mem_we,
		output pc_action
	);

	modport datapath (
		input alu_op,
		input b_src,
		input imm_mode,
		input wr_sel,
		input reg_we,
		input wb_src,
		input mem_we,
		input pc_action
	);

endinterface

// File: mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder (
	input  mips_pkg::opcode_e opcode,
	input  mips_pkg::funct_e  funct,
	mips_ctrl_if.decoder      ctrl
);
	import mips_pkg::*;

	always_comb begin
		// anything not listed below falls through as a no-operation.
		ctrl.alu_op    = alu_add;
		ctrl.b_src     = b_reg;
		ctrl.imm_mode  = imm_signed;
		ctrl.wr_sel    = wr_rd;
		ctrl.reg_we    = 1'b0;
		ctrl.wb_src    = wb_alu;
		ctrl.mem_we    = 1'b0;
		ctrl.pc_action = pc_seq;

		case (opcode)
			op_special: begin
				case (funct)
					fn_sll: begin
						ctrl.alu_op = alu_sll;
						ctrl.b_src  = b_shamt; // shift amount comes from the shamt field.
						ctrl.reg_we = 1'b1;
					end
					fn_jr:   ctrl.pc_action = pc_jr;
					fn_addu: begin
						ctrl.alu_op = alu_add;
						ctrl.reg_we = 1'b1;
					end
					fn_subu: begin
						ctrl.alu_op = alu_sub;
						ctrl.reg_we = 1'b1;
					end
					fn_and: begin
						ctrl.alu_op = alu_and;
						ctrl.reg_we = 1'b1;
					end
					fn_or: begin
						ctrl.alu_op = alu_or;
						ctrl.reg_we = 1'b1;
					end
					fn_slt: begin
						ctrl.alu_op = alu_slt;
						ctrl.reg_we = 1'b1;
					end
					default: ;
				endcase
			end
			op_addiu, op_lw, op_sw: begin
				ctrl.alu_op = alu_add; // both the address and the sum are base plus signed offset.
				ctrl.b_src  = b_imm;
				ctrl.wr_sel = wr_rt;
				ctrl.reg_we = (opcode != op_sw);
				ctrl.mem_we = (opcode == op_sw);
				ctrl.wb_src = (opcode == op_lw) ? wb_mem : wb_alu;
			end
			op_ori, op_lui: begin
				ctrl.alu_op   = (opcode == op_lui) ? alu_lui : alu_or;
				ctrl.b_src    = b_imm;
				ctrl.imm_mode = imm_zero;
				ctrl.wr_sel   = wr_rt;
				ctrl.reg_we   = 1'b1;
			end
			op_beq: begin
				ctrl.alu_op    = alu_sub; // equality is read from the zero flag.
				ctrl.pc_action = pc_beq;
			end
			op_bne: begin
				ctrl.alu_op    = alu_sub;
				ctrl.pc_action = pc_bne;
			end
			op_j: ctrl.pc_action = pc_jump;
			op_jal: begin
				ctrl.pc_action = pc_jump;
				ctrl.wr_sel    = wr_r31;
				ctrl.wb_src    = wb_link;
				ctrl.reg_we    = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile (
	input  logic                clk,
	input  logic                reset,
	input  mips_pkg::reg_addr_t rd1_addr,
	input  mips_pkg::reg_addr_t rd2_addr,
	input  mips_pkg::reg_addr_t wr_addr,
	output mips_pkg::word_t     rd1_data,
	output mips_pkg::word_t     rd2_data,
	input  logic                we,
	input  mips_pkg::word_t     wr_data
);
	import mips_pkg::*;

	word_t regs [1:31]; // register zero has no storage.

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// reads see the old value during a write cycle.
	assign rd1_data = (rd1_addr == '0) ? '0 : regs[rd1_addr];
	assign rd2_data = (rd2_addr == '0) ? '0 : regs[rd2_addr];

endmodule

// File: mips_alu.sv
`timescale 1ns/1ps

module mips_alu (
	mips_ctrl_if.datapath   ctrl,
	input  mips_pkg::word_t a,
	input  mips_pkg::word_t b,
	output mips_pkg::word_t result,
	output logic            zero
);
	import mips_pkg::*;

	logic less; // signed compare for slt.

	assign less = ($signed(a) < $signed(b));

	always_comb begin
		case (ctrl.alu_op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {31'b0, less};
			alu_sll: result = a << b[4:0]; // only the low five bits of a shift count matter.
			alu_lui: result = {b[15:0], 16'h0000};
			default: result = a + b;
		endcase
	end

	// branches run a subtraction, so zero means the operands are equal.
	assign zero = (result == '0);

endmodule

// File: mips_pc.sv
`timescale 1ns/1ps

module mips_pc #(
	parameter mips_pkg::word_t RESET_ADDR = '0
) (
	input  logic            clk,
	input  logic            reset,
	mips_ctrl_if.datapath   ctrl,
	input  logic            zero,
	input  logic [15:0]     offset,
	input  logic [25:0]     target,
	input  mips_pkg::word_t reg_target,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t pc_plus4
);
	import mips_pkg::*;

	word_t branch_addr;
	word_t jump_addr;
	word_t next_pc;
	logic  taken;

	assign pc_plus4    = pc + 32'd4;
	assign branch_addr = pc_plus4 + {{14{offset[15]}}, offset, 2'b00};
	assign jump_addr   = {pc_plus4[31:28], target, 2'b00}; // stays in the current 256 MB region.

	assign taken = (ctrl.pc_action == pc_beq &&  zero) ||
	               (ctrl.pc_action == pc_bne && !zero);

	always_comb begin
		case (ctrl.pc_action)
			pc_beq, pc_bne: next_pc = taken ? branch_addr : pc_plus4;
			pc_jump:        next_pc = jump_addr;
			pc_jr:          next_pc = reg_target;
			default:        next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_ADDR;
		end else begin
			pc <= next_pc;
		end
	end

endmodule

// File: mips_core.sv
`timescale 1ns/1ps

module mips_core #(
	parameter mips_pkg::word_t RESET_ADDR = '0
) (
	input  logic            clk,
	input  logic            reset,
	output mips_pkg::word_t imem_addr,
	input  mips_pkg::word_t imem_data,
	output mips_pkg::word_t dmem_addr,
	output mips_pkg::word_t dmem_wdata,
	output logic            dmem_we,
	input  mips_pkg::word_t dmem_rdata
);
	import mips_pkg::*;

	//////////////////////////////////////////////////
	// instruction fields
	//////////////////////////////////////////////////

	word_t       instr;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [4:0]  shamt;
	logic [15:0] imm;
	logic [25:0] target;

	assign instr  = imem_data; // the fetch answers within the cycle.
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign imm    = instr[15:0];
	assign target = instr[25:0];

	mips_ctrl_if ctrl ();

	mips_decoder i_decoder (
		.opcode (opcode_e'(instr[31:26])),
		.funct  (funct_e'(instr[5:0])),
		.ctrl   (ctrl)
	);

	//////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////

	reg_addr_t rd1_addr;
	reg_addr_t wr_addr;
	word_t     rd1_data;
	word_t     rd2_data;
	word_t     wr_data;
	word_t     pc_plus4;
	word_t     alu_result;

	// sll shifts rt, so port one reads rt for a shift.
	assign rd1_addr = (ctrl.b_src == b_shamt) ? rt : rs;

	always_comb begin
		case (ctrl.wr_sel)
			wr_rt:   wr_addr = rt;
			wr_r31:  wr_addr = 5'd31; // jal links into the return-address register.
			default: wr_addr = rd;
		endcase
	end

	always_comb begin
		case (ctrl.wb_src)
			wb_mem:  wr_data = dmem_rdata;
			wb_link: wr_data = pc_plus4;
			default: wr_data = alu_result;
		endcase
	end

	mips_regfile i_regfile (
		.clk      (clk),
		.reset    (reset),
		.rd1_addr (rd1_addr),
		.rd2_addr (rt),
		.wr_addr  (wr_addr),
		.rd1_data (rd1_data),
		.rd2_data (rd2_data),
		.we       (ctrl.reg_we & ~reset),
		.wr_data  (wr_data)
	);

	//////////////////////////////////////////////////
	// alu operands
	//////////////////////////////////////////////////

	word_t imm_ext;
	word_t alu_b;
	logic  alu_zero;

	assign imm_ext = (ctrl.imm_mode == imm_zero) ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	always_comb begin
		case (ctrl.b_src)
			b_imm:   alu_b = imm_ext;
			b_shamt: alu_b = {27'b0, shamt};
			default: alu_b = rd2_data;
		endcase
	end

	mips_alu i_alu (
		.ctrl   (ctrl),
		.a      (rd1_data),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	mips_pc #(
		.RESET_ADDR (RESET_ADDR)
	) i_pc (
		.clk        (clk),
		.reset      (reset),
		.ctrl       (ctrl),
		.zero       (alu_zero),
		.offset     (imm),
		.target     (target),
		.reg_target (rd1_data),
		.pc         (imem_addr),
		.pc_plus4   (pc_plus4)
	);

	assign dmem_addr  = alu_result;
	assign dmem_wdata = rd2_data;
	assign dmem_we    = ctrl.mem_we & ~reset; // no stores while the core is held in reset.

endmodule

// File: mips_assertions.sv
`timescale 1ns/1ps

module mips_assertions (
	input logic                clk,
	input logic                reset,
	input mips_pkg::word_t     imem_addr,
	input logic                dmem_we,
	input mips_pkg::reg_addr_t rd1_addr,
	input mips_pkg::word_t     rd1_data,
	input mips_pkg::reg_addr_t rd2_addr,
	input mips_pkg::word_t     rd2_data
);
	int fail_count = 0;

	no_store_in_reset: assert property (@(posedge clk) reset |-> !dmem_we)
		else begin
			fail_count++;
			$error("store strobe high during reset");
		end

	fetch_aligned: assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("fetch address is not word aligned");
		end

	// register zero reads zero on both ports, so no write has changed it.
	zero_reg_port1: assert property (@(posedge clk) disable iff (reset)
			(rd1_addr == '0) |-> (rd1_data == '0))
		else begin
			fail_count++;
			$error("register zero read nonzero on port one");
		end

	zero_reg_port2: assert property (@(posedge clk) disable iff (reset)
			(rd2_addr == '0) |-> (rd2_data == '0))
		else begin
			fail_count++;
			$error("register zero read nonzero on port two");
		end

endmodule

bind mips_core mips_assertions i_assertions (
	.clk       (clk),
	.reset     (reset),
	.imem_addr (imem_addr),
	.dmem_we   (dmem_we),
	.rd1_addr  (rd1_addr),
	.rd1_data  (rd1_data),
	.rd2_addr  (rt),
	.rd2_data  (rd2_data)
);

// File: mips_tb.sv
`timescale 1ns/1ps

module mips_tb;
	import mips_pkg::*;

	localparam word_t reset_addr = 32'h0000_0100;
	localparam int max_cycles = 2000; // six short programs need well under 400 cycles.

	logic  clk;
	logic  reset;
	word_t imem_addr;
	word_t imem_data;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic  dmem_we;
	word_t dmem_rdata;

	word_t imem [0:1023];
	word_t dmem [word_t]; // holds preloaded words and every store the core makes.
	word_t wp;
	word_t cur_pc;
	logic  cur_we;
	integer seed;
	int    errors = 0;
	int    checks = 0;
	int    tests = 0;
	int    cycle_count = 0;

	mips_core #(.RESET_ADDR(reset_addr)) i_dut (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// instruction encoding
	//////////////////////////////////////////////////

	function automatic word_t r_type(input funct_e fn, input reg_addr_t rs, input reg_addr_t rt,
			input reg_addr_t rd, input logic [4:0] shamt);
		return {6'h00, rs, rt, rd, shamt, 6'(fn)};
	endfunction

	function automatic word_t i_type(input opcode_e op, input reg_addr_t rs, input reg_addr_t rt,
			input logic [15:0] imm);
		return {6'(op), rs, rt, imm};
	endfunction

	function automatic word_t j_type(input opcode_e op, input logic [25:0] field);
		return {6'(op), field};
	endfunction

	function automatic word_t sign_ext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic word_t branch_dest(input word_t pc, input logic [15:0] off);
		return pc + 32'd4 + (sign_ext16(off) << 2);
	endfunction

	function automatic word_t jump_dest(input word_t pc, input logic [25:0] field);
		word_t next;
		next = pc + 32'd4;
		return {next[31:28], field, 2'b00};
	endfunction

	// unwritten data words read back a value tied to their full address.
	function automatic word_t read_dmem(input word_t addr);
		return dmem.exists(addr) ? dmem[addr] : (addr ^ 32'h5ca1_ab1e);
	endfunction

	//////////////////////////////////////////////////
	// memories, stepping and checks
	//////////////////////////////////////////////////

	task automatic put_at(input word_t addr, input word_t instr);
		imem[addr[11:2]] = instr;
	endtask

	task automatic put(input word_t instr);
		put_at(wp, instr);
		wp = wp + 32'd4;
	endtask

	task automatic load_word(input reg_addr_t r, input word_t value);
		put(i_type(op_lui, 5'd0, r, value[31:16]));
		put(i_type(op_ori, r, r, value[15:0]));
	endtask

	task automatic step(input logic rst);
		@(negedge clk);
		reset = rst;
		imem_data = imem[imem_addr[11:2]];
		#1;
		dmem_rdata = read_dmem(dmem_addr); // load data follows the new instruction's address.
		#1;
		cur_pc = imem_addr;
		cur_we = dmem_we;
		if (dmem_we) begin
			dmem[dmem_addr] = dmem_wdata;
		end
	endtask

	task automatic check_word(input word_t actual, input word_t expected, input string what);
		checks++;
		assert (actual === expected) else begin
			$display("Fail %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic check_store(input word_t addr, input word_t expected, input string what);
		assert (dmem.exists(addr)) else begin
			$display("no store reached address %h for %s by %0d ns", addr, what, $time);
			errors++;
		end
		if (dmem.exists(addr)) begin
			check_word(dmem[addr], expected, what);
		end
	endtask

	task automatic expect_pc(input word_t expected, input string what);
		step(1'b0);
		check_word(cur_pc, expected, what);
	endtask

	task automatic begin_test();
		foreach (imem[i]) begin
			imem[i] = '0;
		end
		dmem.delete();
		wp = reset_addr;
	endtask

	// the core is held in reset for ten cycles, and no store may leak out.
	task automatic release_core();
		repeat (10) begin
			step(1'b1);
			check_word({31'b0, cur_we}, 32'd0, "dmem_we during reset");
		end
	endtask

	task automatic run(input int n);
		repeat (n) step(1'b0);
	endtask

	task automatic finish_test(input string name, input int start);
		tests++;
		$display("%s done with %0d errors", name, errors - start);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		int start;
		start = errors;
		begin_test();
		put(i_type(op_sw, 5'd0, 5'd0, 16'h0040)); // a store waits at the reset address.
		release_core();
		for (int k = 0; k < 6; k++) begin
			expect_pc(reset_addr + 32'(4 * k), "fetch address after reset");
		end
		finish_test("reset", start);
	endtask

	task automatic test_alu();
		word_t a;
		word_t b;
		logic [4:0] sh;
		logic [15:0] imm;
		int start;
		start = errors;
		a = $random(seed);
		b = $random(seed);
		sh = $random(seed);
		imm = $random(seed);
		begin_test();
		load_word(5'd1, a);
		load_word(5'd2, b);
		put(r_type(fn_addu, 5'd1, 5'd2, 5'd3, 5'd0));
		put(r_type(fn_subu, 5'd1, 5'd2, 5'd4, 5'd0));
		put(r_type(fn_and, 5'd1, 5'd2, 5'd5, 5'd0));
		put(r_type(fn_or, 5'd1, 5'd2, 5'd6, 5'd0));
		put(r_type(fn_slt, 5'd1, 5'd2, 5'd7, 5'd0));
		put(r_type(fn_sll, 5'd0, 5'd1, 5'd8, sh));
		put(i_type(op_addiu, 5'd1, 5'd9, imm));
		for (int r = 3; r <= 9; r++) begin
			put(i_type(op_sw, 5'd0, r[4:0], 16'(32'h200 + 4 * (r - 3))));
		end
		release_core();
		run(18);
		check_store(32'h200, a + b, "addu");
		check_store(32'h204, a - b, "subu");
		check_store(32'h208, a & b, "and");
		check_store(32'h20c, a | b, "or");
		check_store(32'h210, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, "slt");
		check_store(32'h214, a << sh, "sll");
		check_store(32'h218, a + sign_ext16(imm), "addiu");
		finish_test("alu", start);
	endtask

	task automatic test_load();
		word_t w;
		logic [15:0] imm;
		int start;
		start = errors;
		w = $random(seed);
		imm = $random(seed);
		begin_test();
		dmem[32'h1300] = w;
		load_word(5'd5, 32'h0000_1000);
		put(i_type(op_lw, 5'd5, 5'd1, 16'h0300));
		put(i_type(op_addiu, 5'd1, 5'd2, imm));
		put(i_type(op_sw, 5'd0, 5'd2, 16'h0304));
		release_core();
		run(5);
		check_store(32'h304, w + sign_ext16(imm), "loaded word plus immediate");
		finish_test("load", start);
	endtask

	task automatic test_branch();
		word_t x;
		word_t b0;
		word_t b1;
		word_t b2;
		word_t b3;
		word_t b4;
		int start;
		start = errors;
		x = $random(seed);
		begin_test();
		load_word(5'd1, x);
		load_word(5'd2, x);
		load_word(5'd3, x ^ 32'h0000_0001);
		b0 = wp;
		b1 = branch_dest(b0, 16'd4); // beq taken.
		b2 = b1 + 32'd4;             // beq not taken.
		b3 = branch_dest(b2, 16'd8); // bne taken.
		b4 = b3 + 32'd4;             // bne not taken.
		put_at(b0, i_type(op_beq, 5'd1, 5'd2, 16'd4));
		put_at(b1, i_type(op_beq, 5'd1, 5'd3, 16'd4));
		put_at(b2, i_type(op_bne, 5'd1, 5'd3, 16'd8));
		put_at(b3, i_type(op_bne, 5'd1, 5'd2, 16'd3));
		put_at(b4, i_type(op_beq, 5'd1, 5'd2, 16'hffec));
		release_core();
		run(6);
		expect_pc(b0, "first branch address");
		expect_pc(b1, "beq taken");
		expect_pc(b2, "beq not taken");
		expect_pc(b3, "bne taken");
		expect_pc(b4, "bne not taken");
		expect_pc(branch_dest(b4, 16'hffec), "backward beq taken");
		finish_test("branch", start);
	endtask

	task automatic test_jump();
		word_t e1;
		word_t e2;
		int start;
		start = errors;
		begin_test();
		e1 = jump_dest(reset_addr, 26'h80);
		e2 = jump_dest(e1, 26'hc0);
		put_at(reset_addr, j_type(op_j, 26'h80));
		put_at(e1, j_type(op_jal, 26'hc0));
		put_at(e2, i_type(op_sw, 5'd0, 5'd31, 16'h0400));
		put_at(e2 + 32'd4, r_type(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));
		release_core();
		expect_pc(reset_addr, "j address");
		expect_pc(e1, "j target");
		expect_pc(e2, "jal target");
		expect_pc(e2 + 32'd4, "jr address");
		expect_pc(e1 + 32'd4, "jr return");
		check_store(32'h400, e1 + 32'd4, "jal link");
		finish_test("jump", start);
	endtask

	task automatic test_zero_reg();
		word_t v;
		int start;
		start = errors;
		v = $random(seed) | 32'h1;
		begin_test();
		load_word(5'd1, v);
		put(r_type(fn_addu, 5'd1, 5'd1, 5'd0, 5'd0));
		put(i_type(op_addiu, 5'd1, 5'd0, 16'd5));
		put(i_type(op_lui, 5'd0, 5'd0, 16'hffff));
		put(i_type(op_sw, 5'd0, 5'd0, 16'h0500));
		release_core();
		run(6);
		check_store(32'h500, 32'd0, "register zero");
		finish_test("zero register", start);
	endtask

	initial begin
		reset = 1'b1;
		imem_data = '0;
		dmem_rdata = '0;
		seed = 32'hd0d1_1427;
		test_reset();
		test_alu();
		test_load();
		test_branch();
		test_jump();
		test_zero_reg();
		errors = errors + i_dut.i_assertions.fail_count;
		$display("%0d tests, %0d checks, %0d errors including assertion failures",
			tests, checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: flist.f
mips_pkg.sv
mips_ctrl_if.sv
mips_decoder.sv
mips_regfile.sv
mips_alu.sv
mips_pc.sv
mips_core.sv
mips_assertions.sv
mips_tb.sv
